// File: flist.f
+incdir+.
cpu_types_pkg.sv
control_unit.sv
register_file.sv
alu.sv
program_counter.sv
cpu_core.sv
tb_cpu_core.sv

// File: Makefile
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_cpu_core: flist.f *.sv cpu_config.svh
	verilator --binary --timing --assert -f flist.f --top-module tb_cpu_core

run: obj_dir/Vtb_cpu_core
	-./obj_dir/Vtb_cpu_core > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module tb_cpu_core

clean:
	rm -rf obj_dir $(LOG)

// File: tb_cpu_core.sv
/*
 Directed testbench for the single-cycle core. Models instruction and data
 memory as arrays, assembles small programs in place, runs each one to HALT
 and checks the stored words against a reference model of the instruction set.
*/

`default_nettype none

`include "cpu_config.svh"

module tb_cpu_core;

   localparam int N_TESTS     = 5;
   localparam int TEST_CYCLES = 2000;
   localparam int CLK_PERIOD  = 8;

   logic clk = 1'b0;
   logic rst_n;
   cpu_types_pkg::word_t instr, dmem_rdata, imem_addr, dmem_addr, dmem_wdata;
   logic dmem_wen, halted;

   cpu_types_pkg::word_t imem [256];
   cpu_types_pkg::word_t dmem [256];
   logic [7:0]  load_ptr;   // Next free instruction slot
   int          write_count;

   always #(CLK_PERIOD / 2) clk = ~clk;

   cpu_core u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .instr      (instr),
      .dmem_rdata (dmem_rdata),
      .imem_addr  (imem_addr),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_wen   (dmem_wen),
      .halted     (halted)
   );

   // Same-cycle reads, data writes on the rising edge
   assign instr      = imem[imem_addr[9:2]];
   assign dmem_rdata = dmem[dmem_addr[9:2]];

   always @(posedge clk) begin
      if (dmem_wen) begin
         dmem[dmem_addr[9:2]] <= dmem_wdata;
         write_count <= write_count + 1;
      end
   end

   function automatic cpu_types_pkg::word_t fill_word(input logic [31:0] addr);
      return {16'hd00d, addr[15:0]};
   endfunction

   function automatic cpu_types_pkg::word_t enc_r(input cpu_types_pkg::funct_t f,
         input int rd, input int rs, input int rt, input int sh);
      return {cpu_types_pkg::RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), f};
   endfunction

   function automatic cpu_types_pkg::word_t enc_i(input cpu_types_pkg::opcode_t op,
         input int rt, input int rs, input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   function automatic cpu_types_pkg::word_t enc_j(input int word_index);
      return {cpu_types_pkg::J, 26'(word_index)};
   endfunction

   // Reference results for the R-type function codes
   function automatic cpu_types_pkg::word_t model_rtype(input cpu_types_pkg::funct_t f,
         input cpu_types_pkg::word_t a, input cpu_types_pkg::word_t b, input logic [4:0] sh);
      case (f)
         cpu_types_pkg::ADD, cpu_types_pkg::ADDU: return a + b;
         cpu_types_pkg::SUB, cpu_types_pkg::SUBU: return a - b;
         cpu_types_pkg::AND:  return a & b;
         cpu_types_pkg::OR:   return a | b;
         cpu_types_pkg::XOR:  return a ^ b;
         cpu_types_pkg::NOR:  return ~(a | b);
         cpu_types_pkg::SLL:  return b << sh;
         cpu_types_pkg::SRL:  return b >> sh;
         cpu_types_pkg::SLT:  return {31'b0, $signed(a) < $signed(b)};
         default:             return {31'b0, a < b};   // SLTU
      endcase
   endfunction

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_word(input logic [31:0] addr, input cpu_types_pkg::word_t exp,
         input string what);
      cpu_types_pkg::word_t got;
      got = dmem[addr[9:2]];
      assert (got === exp)
      else stop_on_error($sformatf("FAIL t=%0t %s: mem[%h] = %h, expected %h",
                                   $time, what, addr, got, exp));
   endtask

   task automatic emit(input cpu_types_pkg::word_t w);
      imem[load_ptr] = w;
      load_ptr = load_ptr + 8'd1;
   endtask

   // Puts the core in reset and clears both memories for a new program
   task automatic start_program();
      @(negedge clk);
      rst_n = 1'b0;
      for (int i = 0; i < 256; i++) begin
         dmem[8'(i)] = fill_word(32'(i) << 2);
         imem[8'(i)] = {cpu_types_pkg::HALT, 26'(i)};
      end
      load_ptr = 8'd0;
   endtask

   task automatic run_program();
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      while (halted !== 1'b1) @(negedge clk);
   endtask

   task automatic test_rtype();
      cpu_types_pkg::funct_t functs [12];
      cpu_types_pkg::word_t  a, b;
      int k, sh;
      functs = '{cpu_types_pkg::ADD, cpu_types_pkg::ADDU, cpu_types_pkg::SUB,
                 cpu_types_pkg::SUBU, cpu_types_pkg::AND, cpu_types_pkg::OR,
                 cpu_types_pkg::XOR, cpu_types_pkg::NOR, cpu_types_pkg::SLL,
                 cpu_types_pkg::SRL, cpu_types_pkg::SLT, cpu_types_pkg::SLTU};
      start_program();
      a = $urandom() | 32'h8000_0000;   // Negative
      b = $urandom() & 32'h7fff_ffff;   // Positive, so SLT and SLTU disagree
      dmem[0] = a;
      dmem[1] = b;
      emit(enc_i(cpu_types_pkg::LW, 1, 0, 0));
      emit(enc_i(cpu_types_pkg::LW, 2, 0, 4));
      for (k = 0; k < 12; k++) begin
         sh = (functs[k] == cpu_types_pkg::SLL || functs[k] == cpu_types_pkg::SRL) ? 5 : 0;
         emit(enc_r(functs[k], 3, 1, 2, sh));
         emit(enc_i(cpu_types_pkg::SW, 3, 0, 'h100 + 4 * k));
      end
      emit({cpu_types_pkg::HALT, 26'd0});
      run_program();
      for (k = 0; k < 12; k++)
         check_word(32'('h100 + 4 * k), model_rtype(functs[k], a, b, 5'd5),
                    $sformatf("R-type %s", functs[k].name()));
   endtask

   task automatic test_shifts();
      int amounts [5];
      cpu_types_pkg::word_t v;
      int k;
      amounts = '{0, 1, 7, 16, 31};
      start_program();
      v = $urandom() | 32'h8000_0001;   // Both end bits set
      dmem[2] = v;
      emit(enc_i(cpu_types_pkg::LW, 1, 0, 8));
      for (k = 0; k < 5; k++) begin
         emit(enc_r(cpu_types_pkg::SLL, 3, 0, 1, amounts[k]));
         emit(enc_i(cpu_types_pkg::SW, 3, 0, 'h140 + 8 * k));
         emit(enc_r(cpu_types_pkg::SRL, 4, 0, 1, amounts[k]));
         emit(enc_i(cpu_types_pkg::SW, 4, 0, 'h144 + 8 * k));
      end
      emit({cpu_types_pkg::HALT, 26'd0});
      run_program();
      for (k = 0; k < 5; k++) begin
         check_word(32'('h140 + 8 * k), v << amounts[k], $sformatf("SLL %0d", amounts[k]));
         check_word(32'('h144 + 8 * k), v >> amounts[k], $sformatf("SRL %0d", amounts[k]));
      end
   endtask

   task automatic test_immediates();
      cpu_types_pkg::word_t v;
      start_program();
      v = $urandom();
      dmem[3] = v;
      emit(enc_i(cpu_types_pkg::ORI, 1, 0, 'h8765));
      emit(enc_i(cpu_types_pkg::ADDIU, 2, 0, -16));
      emit(enc_i(cpu_types_pkg::LW, 5, 0, 12));
      emit(enc_i(cpu_types_pkg::ORI, 3, 5, 'h8765));
      emit(enc_i(cpu_types_pkg::ADDIU, 4, 5, -16));
      for (int r = 1; r <= 4; r++)
         emit(enc_i(cpu_types_pkg::SW, r, 0, 'h17c + 4 * r));
      emit({cpu_types_pkg::HALT, 26'd0});
      run_program();
      check_word(32'h180, 32'h0000_8765, "ORI zero extension");
      check_word(32'h184, 32'hffff_fff0, "ADDIU sign extension");
      check_word(32'h188, v | 32'h0000_8765, "ORI on register");
      check_word(32'h18c, v + 32'hffff_fff0, "ADDIU on register");
   endtask

   task automatic test_control_flow();
      start_program();
      emit(enc_i(cpu_types_pkg::ADDIU, 1, 0, 5));
      emit(enc_i(cpu_types_pkg::ADDIU, 2, 0, 5));
      emit(enc_i(cpu_types_pkg::ADDIU, 3, 0, 7));
      emit(enc_i(cpu_types_pkg::ADDIU, 9, 0, 'h5a5a));   // Marker value
      emit(enc_i(cpu_types_pkg::BEQ, 2, 1, 1));    // Taken
      emit(enc_i(cpu_types_pkg::SW, 9, 0, 'h200));
      emit(enc_i(cpu_types_pkg::SW, 9, 0, 'h204));
      emit(enc_i(cpu_types_pkg::BEQ, 3, 1, 1));    // Not taken
      emit(enc_i(cpu_types_pkg::SW, 9, 0, 'h208));
      emit(enc_i(cpu_types_pkg::BNE, 3, 1, 1));    // Taken
      emit(enc_i(cpu_types_pkg::SW, 9, 0, 'h20c));
      emit(enc_i(cpu_types_pkg::SW, 9, 0, 'h210));
      emit(enc_i(cpu_types_pkg::BNE, 2, 1, 1));    // Not taken
      emit(enc_i(cpu_types_pkg::SW, 9, 0, 'h214));
      emit(enc_j(16));
      emit(enc_i(cpu_types_pkg::SW, 9, 0, 'h218));
      emit(enc_i(cpu_types_pkg::SW, 9, 0, 'h21c));  // Jump target, word 16
      emit({cpu_types_pkg::HALT, 26'd0});
      run_program();
      check_word(32'h200, fill_word(32'h200), "BEQ taken, skipped store");
      check_word(32'h204, 32'h5a5a, "BEQ taken, target store");
      check_word(32'h208, 32'h5a5a, "BEQ not taken");
      check_word(32'h20c, fill_word(32'h20c), "BNE taken, skipped store");
      check_word(32'h210, 32'h5a5a, "BNE taken, target store");
      check_word(32'h214, 32'h5a5a, "BNE not taken");
      check_word(32'h218, fill_word(32'h218), "J, skipped store");
      check_word(32'h21c, 32'h5a5a, "J, target store");
   endtask

   task automatic test_r0_and_halt();
      cpu_types_pkg::word_t halt_pc;
      int writes;
      start_program();
      emit(enc_i(cpu_types_pkg::ADDIU, 0, 0, 'h7777));
      emit(enc_i(cpu_types_pkg::ADDIU, 1, 0, 'h1111));
      emit(enc_r(cpu_types_pkg::ADDU, 0, 1, 1, 0));
      emit(enc_i(cpu_types_pkg::SW, 0, 0, 'h300));
      emit(enc_i(cpu_types_pkg::SW, 1, 0, 'h304));
      emit({cpu_types_pkg::HALT, 26'd0});
      run_program();
      check_word(32'h300, 32'h0, "register zero after writes");
      check_word(32'h304, 32'h1111, "store of r1");
      halt_pc = imem_addr;
      writes  = write_count;
      repeat (20) begin
         @(negedge clk);
         assert (halted === 1'b1 && imem_addr === halt_pc && write_count == writes)
         else stop_on_error($sformatf("FAIL t=%0t core active after HALT: pc %h, writes %0d",
                                      $time, imem_addr, write_count - writes));
      end
      rst_n = 1'b0;
      @(negedge clk);
      assert (halted === 1'b0 && imem_addr === `CPU_RESET_PC)
      else stop_on_error($sformatf("FAIL t=%0t reset left halted=%b pc=%h",
                                   $time, halted, imem_addr));
      run_program();
   endtask

   // Bounds the whole run in case the core never reaches HALT
   initial begin
      #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
      stop_on_error("Timeout: the core never halted within the allowed time");
   end

   initial begin
      void'($urandom(32'ha743));
      rst_n       = 1'b0;
      write_count = 0;
      load_ptr    = 8'd0;
      for (int i = 0; i < 256; i++) begin
         dmem[8'(i)] = fill_word(32'(i) << 2);
         imem[8'(i)] = {cpu_types_pkg::HALT, 26'(i)};
      end
      test_rtype();
      test_shifts();
      test_immediates();
      test_control_flow();
      test_r0_and_halt();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: cpu_core.sv
/*
 Single-cycle core top level. Wires decode, execute and result stages
 together and holds the operand and write-back muxes. Instruction and
 data memories sit outside on plain ports with same-cycle reads.
*/

`default_nettype none

`include "cpu_config.svh"

module cpu_core (
   input  logic                 clk,
   input  logic                 rst_n,
   input  cpu_types_pkg::word_t instr,
   input  cpu_types_pkg::word_t dmem_rdata,
   output cpu_types_pkg::word_t imem_addr,
   output cpu_types_pkg::word_t dmem_addr,
   output cpu_types_pkg::word_t dmem_wdata,
   output logic                 dmem_wen,
   output logic                 halted
);

   // Instruction fields
   cpu_types_pkg::regbits_t rs, rt, rd, shamt;
   cpu_types_pkg::imm16_t   imm;
   cpu_types_pkg::jaddr_t   target;

   // Control levels
   logic reg_dst, ext_signed, alu_src, shift_sel;
   logic mem_wr, mem_to_reg, reg_wr, jump, pc_src, halt;
   cpu_types_pkg::aluop_t alu_op;

   // Datapath
   cpu_types_pkg::regbits_t wsel;
   cpu_types_pkg::word_t    rdata_s, rdata_t;
   cpu_types_pkg::word_t    imm_ext;
   cpu_types_pkg::word_t    alu_a, alu_b, alu_result;
   cpu_types_pkg::word_t    wb_data;
   logic                    alu_zero;

   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign shamt  = instr[10:6];
   assign imm    = instr[15:0];
   assign target = instr[25:0];

   control_unit u_control (
      .instr      (instr),
      .alu_zero   (alu_zero),
      .in_reset   (!rst_n),
      .reg_dst    (reg_dst),
      .ext_signed (ext_signed),
      .alu_src    (alu_src),
      .shift_sel  (shift_sel),
      .mem_wr     (mem_wr),
      .mem_to_reg (mem_to_reg),
      .reg_wr     (reg_wr),
      .jump       (jump),
      .pc_src     (pc_src),
      .halt       (halt),
      .alu_op     (alu_op)
   );

   assign wsel = reg_dst ? rd : rt;

   register_file u_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .wen     (reg_wr),
      .rs      (rs),
      .rt      (rt),
      .wsel    (wsel),
      .wdata   (wb_data),
      .rdata_s (rdata_s),
      .rdata_t (rdata_t)
   );

   // Sign extension for arithmetic and memory offsets, zero for ORI
   assign imm_ext = ext_signed ? {{(`CPU_WORD_W-16){imm[15]}}, imm}
                               : {{(`CPU_WORD_W-16){1'b0}}, imm};

   assign alu_a = shift_sel ? cpu_types_pkg::word_t'(shamt) : rdata_s;
   assign alu_b = alu_src   ? imm_ext : rdata_t;

   alu u_alu (
      .a      (alu_a),
      .b      (alu_b),
      .op     (alu_op),
      .result (alu_result),
      .zero   (alu_zero)
   );

   assign dmem_addr  = alu_result;
   assign dmem_wdata = rdata_t;
   assign dmem_wen   = mem_wr;
   assign wb_data    = mem_to_reg ? dmem_rdata : alu_result;

   program_counter u_pc (
      .clk    (clk),
      .rst_n  (rst_n),
      .pc_src (pc_src),
      .jump   (jump),
      .halt   (halt),
      .imm    (imm),
      .target (target),
      .pc     (imem_addr),
      .halted (halted)
   );

   // A halted core issues no stores and fetches from a fixed address
   a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      halted |-> (!dmem_wen && $stable(imem_addr)))
      else $error("cpu_core: activity after halt");

endmodule

`default_nettype wire

// File: program_counter.sv
/*
 Program counter and halt state. Picks the sequential, branch or jump
 address every cycle, and freezes once a HALT has been decoded.
*/

`default_nettype none

`include "cpu_config.svh"

module program_counter (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    pc_src,
   input  logic                    jump,
   input  logic                    halt,
   input  cpu_types_pkg::imm16_t   imm,
   input  cpu_types_pkg::jaddr_t   target,
   output cpu_types_pkg::word_t    pc,
   output logic                    halted
);

   cpu_types_pkg::word_t pc_plus4;
   cpu_types_pkg::word_t br_addr;
   cpu_types_pkg::word_t j_addr;
   cpu_types_pkg::word_t pc_next;

   assign pc_plus4 = pc + cpu_types_pkg::word_t'(4);
   assign br_addr  = pc_plus4 + {{(`CPU_WORD_W-18){imm[15]}}, imm, 2'b00};
   assign j_addr   = {pc_plus4[`CPU_WORD_W-1 -: 4], target, 2'b00};   // Same 256MB region

   always_comb begin
      if (jump)        pc_next = j_addr;
      else if (pc_src) pc_next = br_addr;
      else             pc_next = pc_plus4;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc     <= `CPU_RESET_PC;
         halted <= 1'b0;
      end else begin
         if (!halt && !halted) pc <= pc_next;
         if (halt) halted <= 1'b1;   // Sticky until reset
      end
   end

   a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
      else $error("program_counter: pc not word aligned");

endmodule

`default_nettype wire

// File: alu.sv
/*
 Combinational ALU for the core. Ten operations selected by op,
 plus a zero flag used for branch resolution.
*/

`default_nettype none

module alu (
   input  cpu_types_pkg::word_t  a,
   input  cpu_types_pkg::word_t  b,
   input  cpu_types_pkg::aluop_t op,
   output cpu_types_pkg::word_t  result,
   output logic                  zero
);

   cpu_types_pkg::regbits_t shamt;

   // Shifts take their amount from the low bits of a
   assign shamt = cpu_types_pkg::regbits_t'(a);

   always_comb begin
      case (op)
         cpu_types_pkg::ALU_ADD:  result = a + b;
         cpu_types_pkg::ALU_SUB:  result = a - b;
         cpu_types_pkg::ALU_AND:  result = a & b;
         cpu_types_pkg::ALU_OR:   result = a | b;
         cpu_types_pkg::ALU_XOR:  result = a ^ b;
         cpu_types_pkg::ALU_NOR:  result = ~(a | b);
         cpu_types_pkg::ALU_SLL:  result = b << shamt;
         cpu_types_pkg::ALU_SRL:  result = b >> shamt;   // Logical, zero fill
         cpu_types_pkg::ALU_SLT: begin
            result = cpu_types_pkg::word_t'($signed(a) < $signed(b));
         end
         cpu_types_pkg::ALU_SLTU: begin
            result = cpu_types_pkg::word_t'(a < b);
         end
         default: result = '0;
      endcase
   end

   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: register_file.sv
/*
 Register file with two combinational read ports and one write port.
 Writes land on the rising edge; register zero is never written.
*/

`default_nettype none

`include "cpu_config.svh"

module register_file (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    wen,
   input  cpu_types_pkg::regbits_t rs,
   input  cpu_types_pkg::regbits_t rt,
   input  cpu_types_pkg::regbits_t wsel,
   input  cpu_types_pkg::word_t    wdata,
   output cpu_types_pkg::word_t    rdata_s,
   output cpu_types_pkg::word_t    rdata_t
);

   cpu_types_pkg::word_t regs [`CPU_REG_N];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (wen && (wsel != '0)) begin   // r0 stays at reset value
         regs[wsel] <= wdata;
      end
   end

   assign rdata_s = regs[rs];
   assign rdata_t = regs[rt];

   // r0 reads zero on both ports, relies on reset and the write guard
   a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
      ((rs == '0) |-> (rdata_s == '0)) and ((rt == '0) |-> (rdata_t == '0)))
      else $error("register_file: register zero read nonzero");

endmodule

`default_nettype wire

// File: control_unit.sv
/*
 Decode stage. Turns the current instruction into datapath control levels
 and resolves the branch decision from the ALU zero flag.
 Purely combinational; in_reset blocks memory writes while rst_n is low.
*/

`default_nettype none

module control_unit (
   input  cpu_types_pkg::word_t  instr,
   input  logic                  alu_zero,
   input  logic                  in_reset,
   output logic                  reg_dst,
   output logic                  ext_signed,
   output logic                  alu_src,
   output logic                  shift_sel,
   output logic                  mem_wr,
   output logic                  mem_to_reg,
   output logic                  reg_wr,
   output logic                  jump,
   output logic                  pc_src,
   output logic                  halt,
   output cpu_types_pkg::aluop_t alu_op
);

   cpu_types_pkg::opcode_t op;
   cpu_types_pkg::funct_t  funct;
   logic                   funct_ok;   // Recognised R-type function

   assign op    = cpu_types_pkg::opcode_t'(instr[31:26]);
   assign funct = cpu_types_pkg::funct_t'(instr[5:0]);

   // R-type writes rd, everything else that writes uses rt
   assign reg_dst    = (op == cpu_types_pkg::RTYPE);
   assign ext_signed = (op != cpu_types_pkg::ORI);   // ORI zero extends
   assign alu_src    = (op == cpu_types_pkg::ORI) || (op == cpu_types_pkg::ADDIU) ||
                       (op == cpu_types_pkg::LW)  || (op == cpu_types_pkg::SW);
   assign shift_sel  = (op == cpu_types_pkg::RTYPE) &&
                       (funct == cpu_types_pkg::SLL || funct == cpu_types_pkg::SRL);

   assign mem_wr     = (op == cpu_types_pkg::SW) && !in_reset;
   assign mem_to_reg = (op == cpu_types_pkg::LW);
   assign reg_wr     = ((op == cpu_types_pkg::RTYPE) && funct_ok) ||
                       (op == cpu_types_pkg::ORI) || (op == cpu_types_pkg::ADDIU) ||
                       (op == cpu_types_pkg::LW);

   assign jump = (op == cpu_types_pkg::J);
   assign halt = (op == cpu_types_pkg::HALT);

   // BNE takes the branch on a nonzero difference
   always_comb begin
      case (op)
         cpu_types_pkg::BEQ: pc_src = alu_zero;
         cpu_types_pkg::BNE: pc_src = !alu_zero;
         default:            pc_src = 1'b0;
      endcase
   end

   always_comb begin
      funct_ok = 1'b1;
      alu_op   = cpu_types_pkg::ALU_ADD;   // ADDIU, LW, SW and no-ops
      case (op)
         cpu_types_pkg::RTYPE: begin
            case (funct)
               cpu_types_pkg::ADD,
               cpu_types_pkg::ADDU: alu_op = cpu_types_pkg::ALU_ADD;
               cpu_types_pkg::SUB,
               cpu_types_pkg::SUBU: alu_op = cpu_types_pkg::ALU_SUB;
               cpu_types_pkg::AND:  alu_op = cpu_types_pkg::ALU_AND;
               cpu_types_pkg::OR:   alu_op = cpu_types_pkg::ALU_OR;
               cpu_types_pkg::XOR:  alu_op = cpu_types_pkg::ALU_XOR;
               cpu_types_pkg::NOR:  alu_op = cpu_types_pkg::ALU_NOR;
               cpu_types_pkg::SLL:  alu_op = cpu_types_pkg::ALU_SLL;
               cpu_types_pkg::SRL:  alu_op = cpu_types_pkg::ALU_SRL;
               cpu_types_pkg::SLT:  alu_op = cpu_types_pkg::ALU_SLT;
               cpu_types_pkg::SLTU: alu_op = cpu_types_pkg::ALU_SLTU;
               default:             funct_ok = 1'b0;   // Executes as no-op
            endcase
         end
         cpu_types_pkg::ORI:  alu_op = cpu_types_pkg::ALU_OR;
         cpu_types_pkg::BEQ,
         cpu_types_pkg::BNE:  alu_op = cpu_types_pkg::ALU_SUB;
         default: ;
      endcase
   end

   // Store and register write never overlap once out of reset
   always_comb begin
      if (!in_reset) begin
         assert (!(mem_wr && reg_wr))
            else $error("control_unit: mem_wr and reg_wr both high");
         assert (alu_op inside {cpu_types_pkg::ALU_ADD, cpu_types_pkg::ALU_SUB,
                                cpu_types_pkg::ALU_AND, cpu_types_pkg::ALU_OR,
                                cpu_types_pkg::ALU_XOR, cpu_types_pkg::ALU_NOR,
                                cpu_types_pkg::ALU_SLL, cpu_types_pkg::ALU_SRL,
                                cpu_types_pkg::ALU_SLT, cpu_types_pkg::ALU_SLTU})
            else $error("control_unit: alu_op outside the defined set");
      end
   end

endmodule

`default_nettype wire

// File: cpu_types_pkg.sv
/*
 Shared datapath and encoding types for the core.
 Modules reference these through scoped names, no import.
*/

`default_nettype none

`include "cpu_config.svh"

package cpu_types_pkg;

   typedef logic [`CPU_WORD_W-1:0]         word_t;     // Data or address word
   typedef logic [$clog2(`CPU_REG_N)-1:0]  regbits_t;  // Register index or shamt
   typedef logic [15:0]                    imm16_t;
   typedef logic [25:0]                    jaddr_t;    // J-type target field

   // Primary opcodes, instr[31:26]
   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      J     = 6'h02,
      BEQ   = 6'h04,
      BNE   = 6'h05,
      ADDIU = 6'h09,
      ORI   = 6'h0d,
      LW    = 6'h23,
      SW    = 6'h2b,
      HALT  = `CPU_HALT_OP
   } opcode_t;

   // R-type function codes, instr[5:0]
   typedef enum logic [5:0] {
      SLL  = 6'h00,
      SRL  = 6'h02,
      ADD  = 6'h20,
      ADDU = 6'h21,
      SUB  = 6'h22,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      XOR  = 6'h26,
      NOR  = 6'h27,
      SLT  = 6'h2a,
      SLTU = 6'h2b
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_NOR, ALU_SLL, ALU_SRL, ALU_SLT, ALU_SLTU
   } aluop_t;

endpackage

`default_nettype wire

// File: cpu_config.svh
/*
 Global sizing and encoding constants for the single-cycle core.
 Include this header in any file that needs word width, register count,
 reset vector or the halt opcode.
*/

`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and address width
`define CPU_WORD_W 32

// Architectural registers, r0 hardwired to zero
`define CPU_REG_N 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Opcode that freezes the program counter
`define CPU_HALT_OP 6'h3f

`endif
